// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tbCounterUnit \
		-f counterUnit.f -o VtbCounterUnit

run: compile
	./obj_dir/VtbCounterUnit

clean:
	rm -rf obj_dir

// File: apbCommandStage.sv
`timescale 1ns/1ns
`default_nettype none

module apbCommandStage
	import dekatronPkg::*;
(
	input logic Step,
	input logic rstN,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [3:0] pAddr,
	input logic [31:0] pWData,
	output logic [31:0] pRData,
	output logic pReady,
	output logic pSlvErr,
	input bcdValue result,
	output counterCmd cmd
);

	logic [7:0] remaining;
	logic stepDown;
	logic [1:0] drain;
	logic busy;
	logic accessDone;
	logic addrKnown;
	logic bcdValid;
	logic loadWrite;
	logic stepWrite;
	logic [10:0] loadDecimal;

	function automatic digitOneHot toOneHot(input logic [3:0] nibble);
		return RING_ZERO << nibble;
	endfunction

	// Decimal value of the write data, only meaningful with valid nibbles
	assign loadDecimal = 11'(pWData[11:8]) * 11'd100 + 11'(pWData[7:4]) * 11'd10
		+ 11'(pWData[3:0]);
	assign bcdValid = pWData[11:8] <= 4'd9 && pWData[7:4] <= 4'd9 && pWData[3:0] <= 4'd9
		&& loadDecimal <= 11'(COUNT_MAX);

	// Steps still queued or the pipeline still draining
	assign busy = (remaining != 8'd0) || (drain != 2'd0);

	// Writes wait out a burst, reads never stall
	assign pReady = !(pWrite && busy);
	assign accessDone = pSel && pEnable && pReady;

	assign loadWrite = accessDone && pWrite && pAddr == REG_VALUE && bcdValid;
	assign stepWrite = accessDone && pWrite && pAddr == REG_STEP && pWData[7:0] != 8'd0;

	always_comb begin
		pRData = '0;
		addrKnown = 1'b1;
		case (pAddr)
			REG_VALUE: pRData = 32'(result);
			REG_STEP: pRData = 32'({stepDown, remaining});
			REG_STATUS: pRData = 32'(busy);
			default: addrKnown = 1'b0;
		endcase
	end

	assign pSlvErr = accessDone
		&& (!addrKnown || (pWrite && pAddr == REG_VALUE && !bcdValid));

	always_ff @(posedge Step or negedge rstN) begin
		if (!rstN) begin
			cmd <= '{op: cmdIdle, reverse: 1'b0, loadOnes: '0, loadTens: '0, loadHundreds: '0};
			remaining <= '0;
			stepDown <= 1'b0;
			drain <= '0;
		end else begin
			cmd.op <= cmdIdle;
			if (drain != 2'd0) begin
				drain <= drain - 2'd1;
			end
			if (loadWrite) begin
				cmd.op <= cmdSet;
				cmd.loadOnes <= toOneHot(pWData[3:0]);
				cmd.loadTens <= toOneHot(pWData[7:4]);
				cmd.loadHundreds <= toOneHot(pWData[11:8]);
				// Rings, then result register
				drain <= 2'd2;
			end else if (stepWrite) begin
				remaining <= pWData[7:0];
				stepDown <= pWData[8];
			end else if (remaining != 8'd0) begin
				cmd.op <= cmdStep;
				cmd.reverse <= stepDown;
				remaining <= remaining - 8'd1;
				// Last step of the burst goes out now
				if (remaining == 8'd1) begin
					drain <= 2'd2;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: bcdResultStage.sv
`timescale 1ns/1ns
`default_nettype none

module bcdResultStage
	import dekatronPkg::*;
(
	input logic Step,
	input logic rstN,
	input counterDigits digits,
	output bcdValue result
);

	bcdValue encoded;

	// Lit cathode number as an 8-4-2-1 nibble
	function automatic logic [3:0] toBcd(input digitOneHot position);
		logic [3:0] nibble;
		nibble = '0;
		for (int n = 0; n < 10; n++) begin
			if (position[n]) begin
				nibble = nibble | 4'(n);
			end
		end
		return nibble;
	endfunction

	assign encoded = {toBcd(digits.hundreds), toBcd(digits.tens), toBcd(digits.ones)};

	always_ff @(posedge Step or negedge rstN) begin
		if (!rstN) begin
			// Matches the rings sitting on 000
			result <= '0;
		end else begin
			result <= encoded;
		end
	end

endmodule

`default_nettype wire

// File: counterUnit.f
dekatronPkg.sv
dekatronDigit.sv
dekatronCounter.sv
apbCommandStage.sv
bcdResultStage.sv
counterUnit.sv
counterUnit_properties.sv
tbCounterUnit.sv

// File: counterUnit.sv
`timescale 1ns/1ns
`default_nettype none

module counterUnit
	import dekatronPkg::*;
(
	input logic Step,
	input logic rstN,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [3:0] pAddr,
	input logic [31:0] pWData,
	output logic [31:0] pRData,
	output logic pReady,
	output logic pSlvErr
);

	counterCmd cmd;
	counterDigits digits;
	bcdValue result;

	// Host side, issues one command per cycle
	apbCommandStage commandStage (
		.Step(Step),
		.rstN(rstN),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWData(pWData),
		.pRData(pRData),
		.pReady(pReady),
		.pSlvErr(pSlvErr),
		.result(result),
		.cmd(cmd)
	);

	dekatronCounter dataCounter (.Step(Step), .rstN(rstN), .cmd(cmd), .digits(digits));

	// Feeds reads of the value register
	bcdResultStage resultStage (.Step(Step), .rstN(rstN), .digits(digits), .result(result));

endmodule

`default_nettype wire

// File: counterUnit_properties.sv
`timescale 1ns/1ns
`default_nettype none

module counterProperties
	import dekatronPkg::*;
(
	input logic Step,
	input logic rstN,
	input counterDigits digits,
	input logic pWrite,
	input logic pSlvErr,
	input logic busy,
	input counterCmd cmd
);

	// Exactly one cathode glows in every ring
	ringOneHot: assert property (@(posedge Step) disable iff (!rstN)
		$onehot(digits.ones) && $onehot(digits.tens) && $onehot(digits.hundreds))
		else $error("ring position is not one-hot");

	// A rejected write sends nothing to the rings
	rejectedWriteIdle: assert property (@(posedge Step) disable iff (!rstN)
		pSlvErr && pWrite |=> cmd.op == cmdIdle)
		else $error("command issued after a rejected write");

	// No command reaches the rings outside a busy window
	idleWhenNotBusy: assert property (@(posedge Step) disable iff (!rstN)
		!busy |-> cmd.op == cmdIdle)
		else $error("command issued while not busy");

endmodule

bind counterUnit counterProperties props (.Step(Step), .rstN(rstN), .digits(digits),
	.pWrite(pWrite), .pSlvErr(pSlvErr), .busy(commandStage.busy), .cmd(cmd));

`default_nettype wire

// File: dekatronCounter.sv
`timescale 1ns/1ns
`default_nettype none

module dekatronCounter
	import dekatronPkg::*;
(
	input logic Step,
	input logic rstN,
	input counterCmd cmd,
	output counterDigits digits
);

	digitOneHot ones;
	digitOneHot tens;
	digitOneHot hundreds;

	// Ring positions of the upper limit
	digitOneHot maxOnes;
	digitOneHot maxTens;
	digitOneHot maxHundreds;

	digitOneHot nextOnes;
	digitOneHot nextTens;
	digitOneHot nextHundreds;

	logic stepping;
	logic atUpLimit;
	logic atDownLimit;
	logic loadAll;
	logic enableOnes;
	logic enableTens;
	logic enableHundreds;

	assign maxOnes = RING_ZERO << (COUNT_MAX % 10);
	assign maxTens = RING_ZERO << ((COUNT_MAX / 10) % 10);
	assign maxHundreds = RING_ZERO << (COUNT_MAX / 100);

	assign stepping = (cmd.op == cmdStep);

	// Next step would leave the 0..255 range
	assign atUpLimit = stepping && !cmd.reverse
		&& ones == maxOnes && tens == maxTens && hundreds == maxHundreds;
	assign atDownLimit = stepping && cmd.reverse && ones[0] && tens[0] && hundreds[0];

	// A limit turns the step into a load of the opposite end
	assign loadAll = atUpLimit || atDownLimit || (cmd.op == cmdSet);

	// Carry on 9 going up, borrow on 0 going down
	assign enableOnes = stepping;
	assign enableTens = enableOnes && (cmd.reverse ? ones[0] : ones[9]);
	assign enableHundreds = enableTens && (cmd.reverse ? tens[0] : tens[9]);

	always_comb begin
		if (cmd.op == cmdSet) begin
			nextOnes = cmd.loadOnes;
			nextTens = cmd.loadTens;
			nextHundreds = cmd.loadHundreds;
		end else if (atDownLimit) begin
			nextOnes = maxOnes;
			nextTens = maxTens;
			nextHundreds = maxHundreds;
		end else begin
			nextOnes = RING_ZERO;
			nextTens = RING_ZERO;
			nextHundreds = RING_ZERO;
		end
	end

	dekatronDigit ringOnes (.Step(Step), .rstN(rstN), .enable(enableOnes), .reverse(cmd.reverse),
		.load(loadAll), .loadValue(nextOnes), .position(ones));
	dekatronDigit ringTens (.Step(Step), .rstN(rstN), .enable(enableTens), .reverse(cmd.reverse),
		.load(loadAll), .loadValue(nextTens), .position(tens));
	dekatronDigit ringHundreds (.Step(Step), .rstN(rstN), .enable(enableHundreds),
		.reverse(cmd.reverse), .load(loadAll), .loadValue(nextHundreds), .position(hundreds));

	assign digits = '{ones: ones, tens: tens, hundreds: hundreds};

endmodule

`default_nettype wire

// File: dekatronDigit.sv
`timescale 1ns/1ns
`default_nettype none

module dekatronDigit
	import dekatronPkg::*;
(
	input logic Step,
	input logic rstN,
	input logic enable,
	input logic reverse,
	input logic load,
	input digitOneHot loadValue,
	output digitOneHot position
);

	digitOneHot rotUp;
	digitOneHot rotDown;

	// Glow moves to the next cathode, 9 wraps back to 0
	assign rotUp = {position[8:0], position[9]};

	// Glow moves to the previous cathode, 0 wraps to 9
	assign rotDown = {position[0], position[9:1]};

	always_ff @(posedge Step or negedge rstN) begin
		if (!rstN) begin
			position <= RING_ZERO;
		end else if (load) begin
			// Load wins over a step in the same cycle
			position <= loadValue;
		end else if (enable) begin
			if (reverse) begin
				position <= rotDown;
			end else begin
				position <= rotUp;
			end
		end
	end

endmodule

`default_nettype wire

// File: dekatronPkg.sv
`default_nettype none

package dekatronPkg;

	// One lit position per ring, bit n lit means digit n
	typedef logic [9:0] digitOneHot;

	// 8-4-2-1 code, hundreds in the top nibble
	typedef logic [11:0] bcdValue;

	typedef enum logic [1:0] {
		cmdIdle,
		cmdSet,
		cmdStep
	} cmdOp;

	// One command per cycle from the APB stage into the rings
	typedef struct packed {
		cmdOp op;
		logic reverse;
		digitOneHot loadOnes;
		digitOneHot loadTens;
		digitOneHot loadHundreds;
	} counterCmd;

	// Ring state as seen by the result stage
	typedef struct packed {
		digitOneHot ones;
		digitOneHot tens;
		digitOneHot hundreds;
	} counterDigits;

	// Ring sitting on position 0
	localparam digitOneHot RING_ZERO = 10'b0000000001;

	// APB register map
	localparam logic [3:0] REG_VALUE = 4'h0;
	localparam logic [3:0] REG_STEP = 4'h4;
	localparam logic [3:0] REG_STATUS = 4'h8;

	// Upper limit of the data counter
	localparam int COUNT_MAX = 255;

endpackage

`default_nettype wire

// File: tbCounterUnit.sv
`timescale 1ns/1ns
`default_nettype none

module tbCounterUnit
	import dekatronPkg::*;
();

	typedef enum {rowRead, rowLoad, rowStep, rowPair} rowKind;

	typedef struct {
		rowKind kind;
		bcdValue value;
		int count;
		logic down;
		int count2;
		logic down2;
		bcdValue expValue;
		logic expErr;
	} testRow;

	localparam int NUM_ROWS = 18;
	localparam int NUM_RANDOM = 16;

	logic Step = 1'b0;
	logic rstN;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [3:0] pAddr;
	logic [31:0] pWData;
	logic [31:0] pRData;
	logic pReady;
	logic pSlvErr;

	testRow rows[NUM_ROWS];
	int randCount[NUM_RANDOM];
	logic randIsLoad[NUM_RANDOM];
	logic randDown[NUM_RANDOM];
	logic [31:0] rngState = 32'd59;
	int model = 0;
	int cycleCount = 0;
	int cycleLimit = 1000;

	counterUnit UUT (.Step(Step), .rstN(rstN), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr));

	always #20 Step = ~Step;

	always @(posedge Step) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run went past %0d clock cycles", cycleLimit);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Decimal 0..255 to three BCD nibbles
	function automatic bcdValue decimalToBcd(input int v);
		return {4'(v / 100), 4'((v / 10) % 10), 4'(v % 10)};
	endfunction

	task automatic checkValue(input string name, input bcdValue expected, input bcdValue actual);
		if (expected !== actual) begin
			$display("ERR %0t %s expected %03h actual %03h", $time, name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Setup, access, then hold until pReady seen at the falling edge
	task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err,
		output int waits);
		waits = 0;
		@(posedge Step);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= 1'b1;
		pAddr <= addr;
		pWData <= data;
		@(posedge Step);
		pEnable <= 1'b1;
		@(negedge Step);
		while (!pReady) begin
			waits++;
			@(negedge Step);
		end
		err = pSlvErr;
		@(posedge Step);
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
		@(posedge Step);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= 1'b0;
		pAddr <= addr;
		@(posedge Step);
		pEnable <= 1'b1;
		@(negedge Step);
		while (!pReady) begin
			@(negedge Step);
		end
		data = pRData;
		err = pSlvErr;
		@(posedge Step);
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic waitIdle();
		logic [31:0] data;
		logic err;
		data = 32'd1;
		while (data[0]) begin
			apbRead(REG_STATUS, data, err);
		end
	endtask

	// Value register against the expected state
	task automatic checkCurrent(input bcdValue expected);
		logic [31:0] data;
		logic err;
		apbRead(REG_VALUE, data, err);
		checkValue("pRData", expected, data[11:0]);
		checkFlag("pSlvErr", 1'b0, err);
	endtask

	// Status register busy flag against the expected level
	task automatic checkBusy(input logic expected);
		logic [31:0] data;
		logic err;
		apbRead(REG_STATUS, data, err);
		checkFlag("busy", expected, data[0]);
		checkFlag("pSlvErr", 1'b0, err);
	endtask

	task automatic loadValue(input bcdValue value, input logic expErr);
		logic err;
		int waits;
		apbWrite(REG_VALUE, 32'(value), err, waits);
		checkFlag("pSlvErr", expErr, err);
		if (!expErr) begin
			model = int'(value[11:8]) * 100 + int'(value[7:4]) * 10 + int'(value[3:0]);
		end
	endtask

	task automatic stepBurst(input int count, input logic down, output int waits);
		logic err;
		apbWrite(REG_STEP, {23'd0, down, 8'(count)}, err, waits);
		checkFlag("pSlvErr", 1'b0, err);
		// A burst keeps busy up well past the first status read
		checkBusy(count != 0);
		model = (((down ? model - count : model + count) % 256) + 256) % 256;
	endtask

	initial begin
		int waits;
		int totalSteps;
		rstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		rows = '{
			'{rowRead, 12'h000, 0, 1'b0, 0, 1'b0, 12'h000, 1'b0},
			'{rowLoad, 12'h123, 0, 1'b0, 0, 1'b0, 12'h123, 1'b0},
			'{rowLoad, 12'h099, 0, 1'b0, 0, 1'b0, 12'h099, 1'b0},
			'{rowLoad, 12'h2A5, 0, 1'b0, 0, 1'b0, 12'h099, 1'b1},
			'{rowLoad, 12'h256, 0, 1'b0, 0, 1'b0, 12'h099, 1'b1},
			'{rowStep, 12'h000, 1, 1'b0, 0, 1'b0, 12'h100, 1'b0},
			'{rowStep, 12'h000, 1, 1'b1, 0, 1'b0, 12'h099, 1'b0},
			'{rowLoad, 12'h000, 0, 1'b0, 0, 1'b0, 12'h000, 1'b0},
			'{rowStep, 12'h000, 1, 1'b1, 0, 1'b0, 12'h255, 1'b0},
			'{rowStep, 12'h000, 1, 1'b0, 0, 1'b0, 12'h000, 1'b0},
			'{rowLoad, 12'h250, 0, 1'b0, 0, 1'b0, 12'h250, 1'b0},
			'{rowStep, 12'h000, 10, 1'b0, 0, 1'b0, 12'h004, 1'b0},
			'{rowStep, 12'h000, 5, 1'b1, 0, 1'b0, 12'h255, 1'b0},
			'{rowStep, 12'h000, 0, 1'b0, 0, 1'b0, 12'h255, 1'b0},
			'{rowLoad, 12'h198, 0, 1'b0, 0, 1'b0, 12'h198, 1'b0},
			'{rowStep, 12'h000, 3, 1'b0, 0, 1'b0, 12'h201, 1'b0},
			'{rowPair, 12'h000, 7, 1'b0, 2, 1'b1, 12'h206, 1'b0},
			'{rowPair, 12'h000, 60, 1'b1, 60, 1'b1, 12'h086, 1'b0}
		};
		totalSteps = 0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			totalSteps += rows[i].count + rows[i].count2;
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			rngState = xorshift(rngState);
			randIsLoad[i] = rngState[0];
			randDown[i] = rngState[1];
			randCount[i] = randIsLoad[i] ? int'(rngState[15:8]) : 1 + int'(rngState[13:8]);
			if (!randIsLoad[i]) begin
				totalSteps += randCount[i];
			end
		end
		cycleLimit = 8 * totalSteps + 40 * (NUM_ROWS + NUM_RANDOM);
		repeat (2) @(posedge Step);
		rstN <= 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			case (rows[i].kind)
				rowRead: checkBusy(1'b0);
				rowLoad: loadValue(rows[i].value, rows[i].expErr);
				rowStep: stepBurst(rows[i].count, rows[i].down, waits);
				rowPair: begin
					stepBurst(rows[i].count, rows[i].down, waits);
					// Second burst must be held back by pReady
					stepBurst(rows[i].count2, rows[i].down2, waits);
					checkFlag("pReady held", 1'b1, waits > 0);
				end
				default: ;
			endcase
			waitIdle();
			checkValue("model", rows[i].expValue, decimalToBcd(model));
			checkCurrent(rows[i].expValue);
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			if (randIsLoad[i]) begin
				loadValue(decimalToBcd(randCount[i]), 1'b0);
			end else begin
				stepBurst(randCount[i], randDown[i], waits);
			end
			waitIdle();
			checkCurrent(decimalToBcd(model));
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
